//--- all.f
+incdir+tests
hw/rv_core_pkg.sv
hw/rv_alu.sv
hw/rv_decoder.sv
hw/rv_regfile.sv
hw/rv_execute.sv
hw/rv_writeback.sv
hw/rv_fetch.sv
hw/rv_core.sv
tests/tb_rv_core.sv

//--- tests/rv_core_tests.svh
/* stimulus rows, included inside the testbench module; assumes reset_pc 32'h8000_0000
   and in-order rows, since later rows read registers written by earlier ones */
`ifndef rv_core_tests_svh
`define rv_core_tests_svh

    // columns: instruction word, then the retire record pc, rd, we, wdata, next_pc
    typedef struct packed {
        rv_core_pkg::word_t   inst;
        rv_core_pkg::retire_t ret;
    } test_row_t;

    localparam int num_rows = 41;

    function automatic test_row_t table_row(input int idx);
        test_row_t r;
        case (idx)
            // x1 = 5, x2 = -3, then register and immediate ALU ops
            0:  r = {32'h00500093, 32'h80000000, 5'd1,  1'b1, 32'h00000005, 32'h80000004};
            1:  r = {32'hFFD00113, 32'h80000004, 5'd2,  1'b1, 32'hFFFFFFFD, 32'h80000008};
            2:  r = {32'h002081B3, 32'h80000008, 5'd3,  1'b1, 32'h00000002, 32'h8000000C};
            3:  r = {32'h40208233, 32'h8000000C, 5'd4,  1'b1, 32'h00000008, 32'h80000010};
            4:  r = {32'h401152B3, 32'h80000010, 5'd5,  1'b1, 32'hFFFFFFFF, 32'h80000014};
            5:  r = {32'h0020B333, 32'h80000014, 5'd6,  1'b1, 32'h00000001, 32'h80000018};
            6:  r = {32'h001123B3, 32'h80000018, 5'd7,  1'b1, 32'h00000001, 32'h8000001C};
            7:  r = {32'h00409413, 32'h8000001C, 5'd8,  1'b1, 32'h00000050, 32'h80000020};
            8:  r = {32'h01C15493, 32'h80000020, 5'd9,  1'b1, 32'h0000000F, 32'h80000024};
            9:  r = {32'h40115513, 32'h80000024, 5'd10, 1'b1, 32'hFFFFFFFE, 32'h80000028};
            10: r = {32'h009445B3, 32'h80000028, 5'd11, 1'b1, 32'h0000005F, 32'h8000002C};
            11: r = {32'h0041E633, 32'h8000002C, 5'd12, 1'b1, 32'h0000000A, 32'h80000030};
            12: r = {32'h0F057693, 32'h80000030, 5'd13, 1'b1, 32'h000000F0, 32'h80000034};
            // lui, auipc
            13: r = {32'h12345737, 32'h80000034, 5'd14, 1'b1, 32'h12345000, 32'h80000038};
            14: r = {32'h00001797, 32'h80000038, 5'd15, 1'b1, 32'h80001038, 32'h8000003C};
            // branches in pairs, taken first; rd is the raw bits 11:7
            15: r = {32'h00108463, 32'h8000003C, 5'd8,  1'b0, 32'h00000000, 32'h80000044};
            16: r = {32'h00208463, 32'h80000044, 5'd8,  1'b0, 32'h00000000, 32'h80000048};
            17: r = {32'h00209663, 32'h80000048, 5'd12, 1'b0, 32'h00000000, 32'h80000054};
            18: r = {32'h00109663, 32'h80000054, 5'd12, 1'b0, 32'h00000000, 32'h80000058};
            19: r = {32'h00114863, 32'h80000058, 5'd16, 1'b0, 32'h00000000, 32'h80000068};
            20: r = {32'h0020C863, 32'h80000068, 5'd16, 1'b0, 32'h00000000, 32'h8000006C};
            21: r = {32'hFE20DCE3, 32'h8000006C, 5'd25, 1'b0, 32'h00000000, 32'h80000064};
            22: r = {32'h00115463, 32'h80000064, 5'd8,  1'b0, 32'h00000000, 32'h80000068};
            23: r = {32'h0020E463, 32'h80000068, 5'd8,  1'b0, 32'h00000000, 32'h80000070};
            24: r = {32'h00116463, 32'h80000070, 5'd8,  1'b0, 32'h00000000, 32'h80000074};
            25: r = {32'h00117463, 32'h80000074, 5'd8,  1'b0, 32'h00000000, 32'h8000007C};
            26: r = {32'h0020F463, 32'h8000007C, 5'd8,  1'b0, 32'h00000000, 32'h80000080};
            // jal +16, jalr x16+5 lands on ...88, jal -8
            27: r = {32'h0100086F, 32'h80000080, 5'd16, 1'b1, 32'h80000084, 32'h80000090};
            28: r = {32'h005808E7, 32'h80000090, 5'd17, 1'b1, 32'h80000094, 32'h80000088};
            29: r = {32'hFF9FF96F, 32'h80000088, 5'd18, 1'b1, 32'h8000008C, 32'h80000080};
            // x0 write, x0 read, then lw, sw, ecall as no-ops
            30: r = {32'h00708013, 32'h80000080, 5'd0,  1'b1, 32'h0000000C, 32'h80000084};
            31: r = {32'h001009B3, 32'h80000084, 5'd19, 1'b1, 32'h00000005, 32'h80000088};
            32: r = {32'h0000AA03, 32'h80000088, 5'd20, 1'b0, 32'h00000000, 32'h8000008C};
            33: r = {32'h00112223, 32'h8000008C, 5'd4,  1'b0, 32'h00000000, 32'h80000090};
            34: r = {32'h00000073, 32'h80000090, 5'd0,  1'b0, 32'h00000000, 32'h80000094};
            // read back links, untouched x20 and the lui result
            35: r = {32'h01288AB3, 32'h80000094, 5'd21, 1'b1, 32'h00000120, 32'h80000098};
            36: r = {32'h00FA0B33, 32'h80000098, 5'd22, 1'b1, 32'h80001038, 32'h8000009C};
            37: r = {32'h40D70BB3, 32'h8000009C, 5'd23, 1'b1, 32'h12344F10, 32'h800000A0};
            // register forms of sll, srl and and
            38: r = {32'h00419C33, 32'h800000A0, 5'd24, 1'b1, 32'h00000200, 32'h800000A4};
            39: r = {32'h00115CB3, 32'h800000A4, 5'd25, 1'b1, 32'h07FFFFFF, 32'h800000A8};
            40: r = {32'h00B57D33, 32'h800000A8, 5'd26, 1'b1, 32'h0000005E, 32'h800000AC};
            default: r = '0;
        endcase
        return r;
    endfunction

`endif

//--- tests/tb_rv_core.sv
/* table-driven testbench for rv_core at the default reset_pc; one strobe per row with
   0 to 3 idle cycles before it, inputs driven 2 ns after the rising edge */
`timescale 1ns/1ps

module tb_rv_core;

    localparam rv_core_pkg::word_t reset_pc = 32'h8000_0000;
    localparam int reset_cycles = 10;

    `include "rv_core_tests.svh"

    localparam int timeout_cycles = num_rows * 6 + reset_cycles;

    logic                 clk;
    logic                 reset;
    rv_core_pkg::word_t   inst_addr;
    rv_core_pkg::inst_u   inst_data;
    logic                 inst_valid;
    logic                 retire_valid;
    rv_core_pkg::retire_t retire;

    int unsigned value_errors = 0;
    int unsigned protocol_errors = 0;
    int unsigned cycle_count = 0;
    logic [31:0] lcg_state;

    rv_core #(
        .reset_pc (reset_pc)
    ) u_dut (
        .clk          (clk),
        .reset        (reset),
        .inst_addr    (inst_addr),
        .inst_data    (inst_data),
        .inst_valid   (inst_valid),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

    always #20 clk = ~clk; // 40 ns period

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout: test did not end within %0d cycles", timeout_cycles);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // all driving and sampling happens just after the edge
    task automatic step_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic check_word(input rv_core_pkg::word_t got, input rv_core_pkg::word_t want,
                              input string what);
        if (got !== want) begin
            value_errors++;
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, want);
        end
    endtask

    task automatic check_retire(input rv_core_pkg::retire_t got,
                                input rv_core_pkg::retire_t want, input int row);
        logic bad;
        bad = got.pc !== want.pc || got.rd !== want.rd || got.we !== want.we
              || got.next_pc !== want.next_pc;
        if (want.we && got.wdata !== want.wdata) // wdata undefined without a write
            bad = 1'b1;
        if (bad) begin
            value_errors++;
            $display("ERR %0t: row %0d retire pc %h rd %0d we %b wdata %h next_pc %h, %s",
                     $time, row, got.pc, got.rd, got.we, got.wdata, got.next_pc,
                     $sformatf("expected pc %h rd %0d we %b wdata %h next_pc %h",
                               want.pc, want.rd, want.we, want.wdata, want.next_pc));
        end
    endtask

    task automatic expect_retire_valid(input logic want, input string when);
        if (retire_valid !== want) begin
            protocol_errors++;
            if (want)
                $display("retire_valid did not pulse %s", when);
            else
                $display("retire_valid was high %s", when);
        end
    endtask

    initial begin
        test_row_t row;
        int        gap;
        clk        = 1'b0;
        reset      = 1'b1;
        inst_data  = '0;
        inst_valid = 1'b0;
        lcg_state  = 32'h6c46e686;
        repeat (reset_cycles) @(posedge clk);
        #2;
        reset = 1'b0;

        check_word(inst_addr, reset_pc, "inst_addr after reset");
        repeat (2) begin
            step_cycle();
            expect_retire_valid(1'b0, "while idle after reset");
        end
        check_word(inst_addr, reset_pc, "inst_addr while idle");

        for (int i = 0; i < num_rows; i++) begin
            row = table_row(i);
            gap = int'((lcg_next() >> 16) % 4);
            repeat (gap) begin
                step_cycle();
                expect_retire_valid(1'b0, $sformatf("on an idle cycle before row %0d", i));
            end
            check_word(inst_addr, row.ret.pc, $sformatf("inst_addr before row %0d", i));
            inst_data  = row.inst;
            inst_valid = 1'b1;
            step_cycle();
            inst_valid = 1'b0;
            inst_data  = '0;   // idle word is never executed
            expect_retire_valid(1'b1, $sformatf("after row %0d", i));
            check_retire(retire, row.ret, i);
            check_word(inst_addr, row.ret.next_pc, $sformatf("inst_addr after row %0d", i));
        end

        step_cycle();
        expect_retire_valid(1'b0, "after the last row");
        $display("checks done: %0d value errors, %0d protocol errors",
                 value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- hw/rv_core.sv
/* single-cycle RV32I core without loads, stores or CSRs; one instruction per inst_valid
   strobe, no back-pressure, retire reported one cycle after the strobe */
`timescale 1ns/1ps

module rv_core #(
    parameter rv_core_pkg::word_t reset_pc = 32'h8000_0000
) (
    input  logic                 clk,
    input  logic                 reset,
    output rv_core_pkg::word_t   inst_addr,
    input  rv_core_pkg::inst_u   inst_data,
    input  logic                 inst_valid,
    output logic                 retire_valid,
    output rv_core_pkg::retire_t retire
);

    rv_core_pkg::word_t   pc;
    rv_core_pkg::word_t   next_pc;
    rv_core_pkg::decode_t dec;
    rv_core_pkg::word_t   rs1_data;
    rv_core_pkg::word_t   rs2_data;
    rv_core_pkg::word_t   alu_result;
    rv_core_pkg::word_t   jump_target;
    rv_core_pkg::word_t   rf_wdata;
    logic                 jump_en;
    logic                 rf_we;

    assign inst_addr = pc;

    rv_fetch #(
        .reset_pc (reset_pc)
    ) u_fetch (
        .clk         (clk),
        .reset       (reset),
        .inst_valid  (inst_valid),
        .jump_en     (jump_en),
        .jump_target (jump_target),
        .pc          (pc),
        .next_pc     (next_pc)
    );

    rv_decoder u_decoder (
        .inst (inst_data),
        .dec  (dec)
    );

    rv_regfile u_regfile (
        .clk    (clk),
        .reset  (reset),
        .we     (rf_we),
        .waddr  (dec.rd),
        .wdata  (rf_wdata),
        .raddr1 (dec.rs1),
        .raddr2 (dec.rs2),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    rv_execute u_execute (
        .dec         (dec),
        .pc          (pc),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .alu_result  (alu_result),
        .jump_en     (jump_en),
        .jump_target (jump_target)
    );

    rv_writeback u_writeback (
        .clk          (clk),
        .reset        (reset),
        .inst_valid   (inst_valid),
        .dec          (dec),
        .pc           (pc),
        .next_pc      (next_pc),
        .alu_result   (alu_result),
        .we           (rf_we),
        .wdata        (rf_wdata),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

endmodule

//--- hw/rv_fetch.sv
/* pc register; reset_pc must be word aligned, pc only moves on a committed instruction */
`timescale 1ns/1ps

module rv_fetch #(
    parameter rv_core_pkg::word_t reset_pc = 32'h8000_0000
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               inst_valid,
    input  logic               jump_en,
    input  rv_core_pkg::word_t jump_target,
    output rv_core_pkg::word_t pc,
    output rv_core_pkg::word_t next_pc
);

    rv_core_pkg::word_t seq_pc;

    assign seq_pc  = pc + 32'd4;
    assign next_pc = jump_en ? jump_target : seq_pc;

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            pc <= reset_pc;
        else if (inst_valid)    // commit edge
            pc <= next_pc;
    end

endmodule

//--- hw/rv_writeback.sv
/* register write select and registered retire record; retire payload has no reset,
   only retire_valid is cleared */
`timescale 1ns/1ps

module rv_writeback (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 inst_valid,
    input  rv_core_pkg::decode_t dec,
    input  rv_core_pkg::word_t   pc,
    input  rv_core_pkg::word_t   next_pc,
    input  rv_core_pkg::word_t   alu_result,
    output logic                 we,
    output rv_core_pkg::word_t   wdata,
    output logic                 retire_valid,
    output rv_core_pkg::retire_t retire
);

    logic writes;

    always_comb begin
        writes = 1'b0;
        wdata  = '0;
        case (dec.opcode)
            rv_core_pkg::op_jal,
            rv_core_pkg::op_jalr: begin
                writes = 1'b1;
                wdata  = pc + 32'd4;    // link address
            end
            rv_core_pkg::op_reg,
            rv_core_pkg::op_imm,
            rv_core_pkg::op_lui,
            rv_core_pkg::op_auipc: begin
                writes = 1'b1;
                wdata  = alu_result;
            end
            default: ; // loads, stores, system and unknown retire as no-ops
        endcase
    end

    assign we = inst_valid && writes; // rd of 0 still raises we

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            retire_valid <= 1'b0;
        else
            retire_valid <= inst_valid;
    end

    always_ff @(posedge clk) begin
        if (inst_valid) begin
            retire.pc      <= pc;
            retire.rd      <= dec.rd;
            retire.we      <= writes;
            retire.wdata   <= wdata;
            retire.next_pc <= next_pc;
        end
    end

endmodule

//--- hw/rv_execute.sv
/* operand select, branch compare and jump target; branch funct3 010/011 never jump */
`timescale 1ns/1ps

module rv_execute (
    input  rv_core_pkg::decode_t dec,
    input  rv_core_pkg::word_t   pc,
    input  rv_core_pkg::word_t   rs1_data,
    input  rv_core_pkg::word_t   rs2_data,
    output rv_core_pkg::word_t   alu_result,
    output logic                 jump_en,
    output rv_core_pkg::word_t   jump_target
);

    rv_core_pkg::word_t alu_a;
    rv_core_pkg::word_t alu_b;
    logic               taken;

    rv_alu u_alu (
        .a      (alu_a),
        .b      (alu_b),
        .op     (dec.alu_op),
        .result (alu_result)
    );

    always_comb begin
        alu_a = rs1_data;
        alu_b = dec.imm;    // immediate forms, jalr, lui
        case (dec.opcode)
            rv_core_pkg::op_reg: alu_b = rs2_data;
            rv_core_pkg::op_auipc,
            rv_core_pkg::op_jal,
            rv_core_pkg::op_branch: alu_a = pc;
            default: ;
        endcase
    end

    // branch condition on the two register values
    always_comb begin
        case (dec.funct3)
            3'b000:  taken = rs1_data == rs2_data;
            3'b001:  taken = rs1_data != rs2_data;
            3'b100:  taken = $signed(rs1_data) < $signed(rs2_data);
            3'b101:  taken = $signed(rs1_data) >= $signed(rs2_data);
            3'b110:  taken = rs1_data < rs2_data;
            3'b111:  taken = rs1_data >= rs2_data;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        jump_en     = 1'b0;
        jump_target = alu_result;
        case (dec.opcode)
            rv_core_pkg::op_jal:    jump_en = 1'b1;
            rv_core_pkg::op_branch: jump_en = taken;
            rv_core_pkg::op_jalr: begin
                jump_en     = 1'b1;
                jump_target = {alu_result[31:1], 1'b0}; // low bit cleared
            end
            default: ;
        endcase
    end

endmodule

//--- hw/rv_regfile.sv
/* 32 x 32 register file, reads are combinational; x0 is never written so it reads zero */
`timescale 1ns/1ps

module rv_regfile (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  we,
    input  rv_core_pkg::reg_idx_t waddr,
    input  rv_core_pkg::word_t    wdata,
    input  rv_core_pkg::reg_idx_t raddr1,
    input  rv_core_pkg::reg_idx_t raddr2,
    output rv_core_pkg::word_t    rdata1,
    output rv_core_pkg::word_t    rdata2
);

    rv_core_pkg::word_t regs [32];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int k = 0; k < 32; k++) begin
                regs[k] <= '0;
            end
        end else if (we && waddr != '0) begin // writes to x0 dropped
            regs[waddr] <= wdata;
        end
    end

    // new value visible the cycle after the write edge
    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

endmodule

//--- hw/rv_decoder.sv
/* combinational RV32I decode; unknown opcodes give format none and a zero immediate */
`timescale 1ns/1ps

module rv_decoder (
    input  rv_core_pkg::inst_u   inst,
    output rv_core_pkg::decode_t dec
);

    rv_core_pkg::opcode_e opcode;
    rv_core_pkg::fmt_e    fmt;
    rv_core_pkg::word_t   imm;
    rv_core_pkg::alu_op_e alu_op;
    logic [6:0]           funct7;

    assign opcode = rv_core_pkg::opcode_e'(inst.r.opcode);
    assign funct7 = inst.r.funct7;

    always_comb begin
        case (opcode)
            rv_core_pkg::op_reg:    fmt = rv_core_pkg::fmt_r;
            rv_core_pkg::op_imm,
            rv_core_pkg::op_jalr,
            rv_core_pkg::op_load,
            rv_core_pkg::op_system: fmt = rv_core_pkg::fmt_i;
            rv_core_pkg::op_store:  fmt = rv_core_pkg::fmt_s;
            rv_core_pkg::op_branch: fmt = rv_core_pkg::fmt_b;
            rv_core_pkg::op_lui,
            rv_core_pkg::op_auipc:  fmt = rv_core_pkg::fmt_u;
            rv_core_pkg::op_jal:    fmt = rv_core_pkg::fmt_j;
            default:                fmt = rv_core_pkg::fmt_none;
        endcase
    end

    // sign-extended immediate per format
    always_comb begin
        case (fmt)
            rv_core_pkg::fmt_i: imm = {{20{inst.i.imm[11]}}, inst.i.imm};
            rv_core_pkg::fmt_s: imm = {{20{inst.s.imm_11_5[6]}}, inst.s.imm_11_5, inst.s.imm_4_0};
            rv_core_pkg::fmt_b: imm = {{19{inst.b.imm_12}}, inst.b.imm_12, inst.b.imm_11,
                                       inst.b.imm_10_5, inst.b.imm_4_1, 1'b0};
            rv_core_pkg::fmt_u: imm = {inst.u.imm_31_12, 12'b0};
            rv_core_pkg::fmt_j: imm = {{11{inst.j.imm_20}}, inst.j.imm_20, inst.j.imm_19_12,
                                       inst.j.imm_11, inst.j.imm_10_1, 1'b0};
            default:            imm = '0;
        endcase
    end

    always_comb begin
        alu_op = rv_core_pkg::alu_add; // address and link arithmetic
        if (opcode == rv_core_pkg::op_lui) begin
            alu_op = rv_core_pkg::alu_pass_b;
        end else if (opcode == rv_core_pkg::op_reg || opcode == rv_core_pkg::op_imm) begin
            case (inst.r.funct3)
                3'b000: begin
                    if (opcode == rv_core_pkg::op_reg && funct7[5])
                        alu_op = rv_core_pkg::alu_sub; // no subi in rv32i
                end
                3'b001:  alu_op = rv_core_pkg::alu_sll;
                3'b010:  alu_op = rv_core_pkg::alu_slt;
                3'b011:  alu_op = rv_core_pkg::alu_sltu;
                3'b100:  alu_op = rv_core_pkg::alu_xor;
                3'b101:  alu_op = funct7[5] ? rv_core_pkg::alu_sra : rv_core_pkg::alu_srl;
                3'b110:  alu_op = rv_core_pkg::alu_or;
                default: alu_op = rv_core_pkg::alu_and;
            endcase
        end
    end

    always_comb begin
        dec.opcode = opcode;
        dec.funct3 = inst.r.funct3;
        dec.rs1    = inst.r.rs1;
        dec.rs2    = inst.r.rs2;
        dec.rd     = inst.r.rd;     // raw field, also for formats without rd
        dec.fmt    = fmt;
        dec.alu_op = alu_op;
        dec.imm    = imm;
    end

endmodule

//--- hw/rv_alu.sv
/* 32-bit ALU; shift amount taken from b[4:0], compares return 0 or 1 */
`timescale 1ns/1ps

module rv_alu (
    input  rv_core_pkg::word_t   a,
    input  rv_core_pkg::word_t   b,
    input  rv_core_pkg::alu_op_e op,
    output rv_core_pkg::word_t   result
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            rv_core_pkg::alu_add:    result = a + b;
            rv_core_pkg::alu_sub:    result = a - b;
            rv_core_pkg::alu_sll:    result = a << shamt;
            rv_core_pkg::alu_slt:    result = {31'b0, $signed(a) < $signed(b)};
            rv_core_pkg::alu_sltu:   result = {31'b0, a < b};
            rv_core_pkg::alu_xor:    result = a ^ b;
            rv_core_pkg::alu_srl:    result = a >> shamt;
            rv_core_pkg::alu_sra:    result = $signed(a) >>> shamt; // keeps sign
            rv_core_pkg::alu_or:     result = a | b;
            rv_core_pkg::alu_and:    result = a & b;
            rv_core_pkg::alu_pass_b: result = b;                    // lui
            default:                 result = '0;
        endcase
    end

endmodule

//--- hw/rv_core_pkg.sv
/* shared RV32I types; only the formats and opcodes used by the core are named.
   opcodes outside opcode_e decode to format none and retire as no-ops */
package rv_core_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0]      reg_idx_t;

    // instruction views, msb first
    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } inst_u;

    typedef enum logic [6:0] {
        op_reg    = 7'b0110011,
        op_imm    = 7'b0010011,
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_system = 7'b1110011
    } opcode_e;

    typedef enum logic [2:0] {
        fmt_r, fmt_i, fmt_s, fmt_b, fmt_u, fmt_j, fmt_none
    } fmt_e;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
        alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
    } alu_op_e;

    typedef struct packed {
        opcode_e    opcode;
        logic [2:0] funct3;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        reg_idx_t   rd;
        fmt_e       fmt;
        alu_op_e    alu_op;
        word_t      imm;
    } decode_t;

    typedef struct packed {
        word_t    pc;
        reg_idx_t rd;
        logic     we;
        word_t    wdata;
        word_t    next_pc;
    } retire_t;

endpackage
